/* Makefile */
TOP := tb_simd_issue

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f verilog.f
	verilator --lint-only -Wall --top-module simd_issue_top \
		design/simd_issue_pkg.sv design/issue_if.sv design/complete_if.sv \
		design/simd_issue_buffer.sv design/simd_scoreboard.sv \
		design/simd_wb_queue.sv design/simd_issue_top.sv

obj_dir/V$(TOP): verilog.f design/*.sv dv/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -Mdir obj_dir

sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

/* design/complete_if.sv */
`timescale 1ns/1ps

interface complete_if
    import simd_issue_pkg::*;
();

    logic             valid;
    tag_t             tag;
    logic [CNT_W-1:0] inflight;
    logic             credit_ok;

    // Completions have no ready, the credit check keeps the queue from overflowing
    modport sb (output valid, output tag, output inflight, input credit_ok);

    modport wb (input valid, input tag, input inflight, output credit_ok);

endinterface

/* design/issue_if.sv */
`timescale 1ns/1ps

interface issue_if
    import simd_issue_pkg::*;
();

    logic      valid;
    logic      ready;
    op_class_t op;
    sew_t      sew;
    tag_t      tag;

    // The issue buffer presents the instruction
    modport src (output valid, output op, output sew, output tag, input ready);

    // The scoreboard decides when it is taken
    modport dst (input valid, input op, input sew, input tag, output ready);

endinterface

/* design/simd_issue_buffer.sv */
`timescale 1ns/1ps

module simd_issue_buffer
    import simd_issue_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      flush_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    input  op_class_t in_op_i,
    input  sew_t      in_sew_i,
    input  tag_t      in_tag_i,
    issue_if.src      issue
);

    logic      full_q;
    op_class_t op_q;
    sew_t      sew_q;
    tag_t      tag_q;
    logic      drain;
    logic      load;

    assign drain = full_q & issue.ready;

    // Room exists when empty or when the held entry leaves this cycle.
    // Nothing is taken during a flush, so no instruction is silently dropped
    assign in_ready_o = (~full_q | drain) & ~flush_i;
    assign load       = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            full_q <= 1'b0;
        end else if (flush_i) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (drain) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            op_q  <= in_op_i;
            sew_q <= in_sew_i;
            tag_q <= in_tag_i;
        end
    end

    assign issue.valid = full_q;
    assign issue.op    = op_q;
    assign issue.sew   = sew_q;
    assign issue.tag   = tag_q;

    // A stalled instruction must still be offered unchanged one cycle later
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (issue.valid && !issue.ready && !flush_i) |=>
            (issue.valid && $stable({issue.op, issue.sew, issue.tag})));

endmodule

/* design/simd_issue_pkg.sv */
package simd_issue_pkg;

    // Instruction tag that comes back with the completion
    typedef logic [3:0] tag_t;

    // Execution latency in cycles
    typedef logic [4:0] lat_t;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_MUL,
        OP_MACC,
        OP_RED,
        OP_DIV
    } op_class_t;

    // Element width, encoded as in vsew
    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_t;

    typedef enum logic {
        DIV_IDLE,
        DIV_BUSY
    } sb_state_t;

    localparam int VLEN = 128;

    // log2 of the vector length in bytes, the depth of the reduction tree
    localparam int RED_BASE = $clog2(VLEN / 8);

    localparam lat_t LAT_ALU  = 5'd1;
    localparam lat_t LAT_MUL  = 5'd2;
    localparam lat_t LAT_MACC = 5'd3;
    localparam lat_t DIV_LAT  = 5'd31;

    localparam int RES_DEPTH = 32;
    localparam int WB_DEPTH  = 4;
    localparam int WB_PTR_W  = $clog2(WB_DEPTH);
    localparam int CNT_W     = 6;

endpackage

/* design/simd_issue_top.sv */
`timescale 1ns/1ps

module simd_issue_top
    import simd_issue_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      flush_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    input  op_class_t in_op_i,
    input  sew_t      in_sew_i,
    input  tag_t      in_tag_i,
    output logic      wb_valid_o,
    input  logic      wb_ready_i,
    output tag_t      wb_tag_o
);

    issue_if    issue ();
    complete_if cpl ();

    simd_issue_buffer u_buffer (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .flush_i    (flush_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_op_i    (in_op_i),
        .in_sew_i   (in_sew_i),
        .in_tag_i   (in_tag_i),
        .issue      (issue.src)
    );

    simd_scoreboard u_scoreboard (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (flush_i),
        .issue   (issue.dst),
        .cpl     (cpl.sb)
    );

    // The queue is not flushed, finished results still drain
    simd_wb_queue u_wb_queue (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .cpl        (cpl.wb),
        .wb_valid_o (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .wb_tag_o   (wb_tag_o)
    );

endmodule

/* design/simd_scoreboard.sv */
`timescale 1ns/1ps

module simd_scoreboard
    import simd_issue_pkg::*;
(
    input  logic clk_i,
    input  logic rstn_i,
    input  logic flush_i,
    issue_if.dst issue,
    complete_if.sb cpl
);

    // Slot i holds the instruction that writes back i+1 cycles from now
    logic [RES_DEPTH-1:0] res_vld_q;
    logic [RES_DEPTH-1:0] res_vld_d;
    logic [RES_DEPTH-1:0] res_div_q;
    logic [RES_DEPTH-1:0] res_div_d;
    logic [RES_DEPTH-1:0] shift_vld;
    tag_t                 res_tag_q [RES_DEPTH];
    tag_t                 res_tag_d [RES_DEPTH];

    sb_state_t div_state_q;
    sb_state_t div_state_d;

    lat_t             lat;
    lat_t             slot;
    logic             is_div;
    logic             accept;
    logic [CNT_W-1:0] occupied;

    function automatic lat_t decode_lat(input op_class_t op, input sew_t sew);
        case (op)
            OP_MUL:  decode_lat = (sew == SEW_64) ? LAT_MUL + 5'd1 : LAT_MUL;
            OP_MACC: decode_lat = (sew == SEW_64) ? LAT_MACC + 5'd1 : LAT_MACC;
            OP_RED: begin
                // Wider elements leave fewer levels in the reduction tree
                case (sew)
                    SEW_8, SEW_16: decode_lat = lat_t'(RED_BASE + 1);
                    SEW_32:        decode_lat = lat_t'(RED_BASE);
                    default:       decode_lat = lat_t'(RED_BASE - 1);
                endcase
            end
            OP_DIV:  decode_lat = DIV_LAT;
            default: decode_lat = LAT_ALU;
        endcase
    endfunction

    assign lat    = decode_lat(issue.op, issue.sew);
    assign slot   = lat - 5'd1;
    assign is_div = (issue.op == OP_DIV);

    // Table contents after this cycle's shift, before any new write
    assign shift_vld = {1'b0, res_vld_q[RES_DEPTH-1:1]};

    assign issue.ready = ~flush_i & ~shift_vld[slot] & cpl.credit_ok &
                         (~is_div | (div_state_q == DIV_IDLE));
    assign accept      = issue.valid & issue.ready;

    always_comb begin
        res_vld_d = shift_vld;
        res_div_d = {1'b0, res_div_q[RES_DEPTH-1:1]};
        for (int i = 0; i < RES_DEPTH - 1; i++) begin
            res_tag_d[i] = res_tag_q[i+1];
        end
        res_tag_d[RES_DEPTH-1] = res_tag_q[RES_DEPTH-1];
        if (accept) begin
            res_vld_d[slot] = 1'b1;
            res_div_d[slot] = is_div;
            res_tag_d[slot] = issue.tag;
        end
        if (flush_i) begin
            res_vld_d = '0;
            res_div_d = '0;
        end
    end

    // The divider frees up when its instruction drops out of slot 0
    always_comb begin
        div_state_d = div_state_q;
        case (div_state_q)
            DIV_IDLE: if (accept && is_div) div_state_d = DIV_BUSY;
            DIV_BUSY: if (res_vld_q[0] && res_div_q[0]) div_state_d = DIV_IDLE;
            default:  div_state_d = DIV_IDLE;
        endcase
        if (flush_i) begin
            div_state_d = DIV_IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            res_vld_q   <= '0;
            res_div_q   <= '0;
            div_state_q <= DIV_IDLE;
        end else begin
            res_vld_q   <= res_vld_d;
            res_div_q   <= res_div_d;
            div_state_q <= div_state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        res_tag_q <= res_tag_d;
    end

    always_comb begin
        occupied = '0;
        for (int i = 0; i < RES_DEPTH; i++) begin
            occupied = occupied + CNT_W'(res_vld_q[i]);
        end
    end

    assign cpl.valid    = res_vld_q[0];
    assign cpl.tag      = res_tag_q[0];
    assign cpl.inflight = occupied;

    // A new entry adds to the occupancy instead of replacing one already in the table
    a_no_overwrite: assert property (@(posedge clk_i) disable iff (!rstn_i)
        accept |=> (occupied == $past(occupied) - CNT_W'($past(res_vld_q[0])) + CNT_W'(1)));

    // The FSM and the per-slot divide flags have to agree
    a_single_div: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (accept && is_div) |-> (res_div_q == '0));

endmodule

/* design/simd_wb_queue.sv */
`timescale 1ns/1ps

module simd_wb_queue
    import simd_issue_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,
    complete_if.wb cpl,
    output logic   wb_valid_o,
    input  logic   wb_ready_i,
    output tag_t   wb_tag_o
);

    tag_t                mem_q [WB_DEPTH];
    logic [WB_PTR_W-1:0] wr_ptr_q;
    logic [WB_PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0]    cnt_q;
    logic [CNT_W-1:0]    free_cnt;
    logic                push;
    logic                pop;

    assign push = cpl.valid;
    assign pop  = wb_valid_o & wb_ready_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= cpl.tag;
        end
    end

    assign wb_valid_o = (cnt_q != '0);
    assign wb_tag_o   = mem_q[rd_ptr_q];

    // Every instruction in the table already owns one queue entry,
    // a new issue needs one more on top of that
    assign free_cnt      = CNT_W'(WB_DEPTH) - cnt_q;
    assign cpl.credit_ok = (free_cnt > cpl.inflight);

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cpl.valid |-> (cnt_q < CNT_W'(WB_DEPTH)));

endmodule

/* dv/tb_simd_issue.sv */
`timescale 1ns/1ps

module tb_simd_issue
    import simd_issue_pkg::*;
();

    // Rough cycle budget per test, the margin covers reset and idle gaps
    localparam int LEN_LATENCY      = 800;
    localparam int LEN_CONFLICT     = 100;
    localparam int LEN_DIVIDE       = 150;
    localparam int LEN_BACKPRESSURE = 800;
    localparam int LEN_FLUSH        = 150;
    localparam int WATCHDOG_CYCLES  = LEN_LATENCY + LEN_CONFLICT + LEN_DIVIDE +
                                      LEN_BACKPRESSURE + LEN_FLUSH + 3000;

    logic      clk_i;
    logic      rstn_i;
    logic      flush_i;
    logic      in_valid_i;
    logic      in_ready_o;
    op_class_t in_op_i;
    sew_t      in_sew_i;
    tag_t      in_tag_i;
    logic      wb_valid_o;
    logic      wb_ready_i;
    tag_t      wb_tag_o;

    int   cycle = 0;
    int   seed;
    int   valid_seen;
    tag_t ret_tag[$];
    int   ret_edge[$];

    simd_issue_top UUT (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .flush_i    (flush_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_op_i    (in_op_i),
        .in_sew_i   (in_sew_i),
        .in_tag_i   (in_tag_i),
        .wb_valid_o (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .wb_tag_o   (wb_tag_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Counts rising edges, so after edge e the value is e
    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    // Sampled just after the falling edge, where the values for the next edge are settled
    always @(negedge clk_i) begin
        #1;
        if (wb_valid_o) begin
            valid_seen++;
        end
        if (wb_valid_o && wb_ready_i) begin
            ret_tag.push_back(wb_tag_o);
            ret_edge.push_back(cycle);
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic cmp_tag(input string test, input tag_t exp, input tag_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s: expected tag %0d, actual %0d", test, exp, act));
        end
    endtask

    task automatic cmp_lat(input string test, input lat_t exp, input lat_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s: expected latency %0d, actual %0d", test, exp, act));
        end
    endtask

    // Execution latency straight from the class and element width table
    function automatic lat_t rule_latency(input op_class_t op, input sew_t sew);
        lat_t lat;
        case (op)
            OP_ALU:  lat = 5'd1;
            OP_MUL:  lat = (sew == SEW_64) ? 5'd3 : 5'd2;
            OP_MACC: lat = (sew == SEW_64) ? 5'd4 : 5'd3;
            OP_RED: begin
                if (sew == SEW_32) begin
                    lat = 5'd4;
                end else if (sew == SEW_64) begin
                    lat = 5'd3;
                end else begin
                    lat = 5'd5;
                end
            end
            default: lat = 5'd31;
        endcase
        return lat;
    endfunction

    task automatic clear_returns();
        ret_tag.delete();
        ret_edge.delete();
    endtask

    task automatic wait_returns(input int n);
        while (ret_tag.size() < n) begin
            @(negedge clk_i);
        end
    endtask

    // Entered and left on a falling edge, acc is the edge that took the instruction
    task automatic try_issue(input op_class_t op, input sew_t sew, input tag_t tag,
                             input int max_wait, output bit ok, output int acc);
        int waited;
        waited     = 0;
        ok         = 1'b0;
        acc        = 0;
        in_valid_i = 1'b1;
        in_op_i    = op;
        in_sew_i   = sew;
        in_tag_i   = tag;
        #1;
        while (!in_ready_o && waited < max_wait) begin
            @(negedge clk_i);
            #1;
            waited++;
        end
        if (in_ready_o) begin
            ok  = 1'b1;
            acc = cycle + 1;
        end
        @(negedge clk_i);
        in_valid_i = 1'b0;
    endtask

    task automatic issue_instr(input op_class_t op, input sew_t sew, input tag_t tag,
                               output int acc);
        bit ok;
        try_issue(op, sew, tag, 60, ok, acc);
        if (!ok) begin
            abort_run("in_ready_o never rose, the instruction was not accepted");
        end
    endtask

    task automatic check_latencies();
        op_class_t op;
        sew_t      sew;
        tag_t      tag;
        string     name;
        int        acc;
        int        measured;
        int        o;
        int        s;
        for (o = 0; o < 5; o++) begin
            for (s = 0; s < 4; s++) begin
                op   = op_class_t'(o);
                sew  = sew_t'(s);
                tag  = tag_t'(o * 4 + s);
                name = $sformatf("latency op%0d sew%0d", o, s);
                clear_returns();
                issue_instr(op, sew, tag, acc);
                wait_returns(1);
                measured = ret_edge[0] - acc;
                if (measured < 1 || measured > 32) begin
                    abort_run($sformatf("ERR %s: expected latency %0d, actual %0d",
                                        name, rule_latency(op, sew), measured - 1));
                end
                cmp_tag(name, tag, ret_tag[0]);
                cmp_lat(name, rule_latency(op, sew), lat_t'(measured - 1));
            end
        end
    endtask

    task automatic check_wb_conflict();
        op_class_t ops [3];
        tag_t      tags [3];
        int        due [3];
        bit        used [3];
        int        acc;
        int        best;
        int        i;
        int        k;
        // The MUL aims at the MACC's writeback cycle and the ALU then at the MUL's
        ops[0] = OP_MACC;
        ops[1] = OP_MUL;
        ops[2] = OP_ALU;
        clear_returns();
        for (i = 0; i < 3; i++) begin
            tags[i] = tag_t'(i + 8);
            used[i] = 1'b0;
            issue_instr(ops[i], SEW_8, tags[i], acc);
            due[i] = acc + int'(rule_latency(ops[i], SEW_8));
        end
        wait_returns(3);
        repeat (40) @(negedge clk_i);
        if (ret_tag.size() != 3) begin
            abort_run("conflict: a tag came back more than once");
        end
        // Results must leave in order of accept edge plus latency.
        // On equal due edges the earlier instruction keeps the slot
        for (k = 0; k < 3; k++) begin
            best = -1;
            for (i = 0; i < 3; i++) begin
                if (!used[i] && (best < 0 || due[i] < due[best])) begin
                    best = i;
                end
            end
            used[best] = 1'b1;
            cmp_tag("conflict", tags[best], ret_tag[k]);
            if (ret_edge[k] < due[best] + 1) begin
                abort_run($sformatf("ERR conflict: expected return at edge %0d or later, actual %0d",
                                    due[best] + 1, ret_edge[k]));
            end
        end
    endtask

    task automatic check_div_serial();
        int acc;
        int gap;
        clear_returns();
        issue_instr(OP_DIV, SEW_32, 4'd1, acc);
        issue_instr(OP_DIV, SEW_32, 4'd2, acc);
        #1;
        if (in_ready_o !== 1'b0) begin
            abort_run("divide: in_ready_o stayed high behind a busy divider");
        end
        wait_returns(2);
        cmp_tag("divide", 4'd1, ret_tag[0]);
        cmp_tag("divide", 4'd2, ret_tag[1]);
        gap = ret_edge[1] - ret_edge[0];
        if (gap < int'(rule_latency(OP_DIV, SEW_32))) begin
            abort_run($sformatf("ERR divide: expected gap of at least %0d, actual %0d",
                                rule_latency(OP_DIV, SEW_32), gap));
        end
    endtask

    task automatic check_backpressure();
        op_class_t op;
        sew_t      sew;
        tag_t      issued[$];
        tag_t      got[$];
        bit        ok;
        int        acc;
        int        i;
        clear_returns();
        wb_ready_i = 1'b0;
        ok         = 1'b1;
        i          = 0;
        // Keep offering until an instruction sits unaccepted for 40 cycles
        while (ok && i < 12) begin
            op  = op_class_t'($unsigned($random(seed)) % 5);
            sew = sew_t'($unsigned($random(seed)) % 4);
            try_issue(op, sew, tag_t'(i), 40, ok, acc);
            if (ok) begin
                issued.push_back(tag_t'(i));
            end
            i++;
        end
        if (ok) begin
            abort_run("backpressure: in_ready_o never fell with wb_ready_i low");
        end
        wb_ready_i = 1'b1;
        wait_returns(issued.size());
        repeat (40) @(negedge clk_i);
        if (ret_tag.size() != issued.size()) begin
            abort_run("backpressure: more tags came back than were issued");
        end
        got = ret_tag;
        got.sort();
        issued.sort();
        for (i = 0; i < issued.size(); i++) begin
            cmp_tag("backpressure", issued[i], got[i]);
        end
    endtask

    task automatic check_flush();
        int acc;
        clear_returns();
        valid_seen = 0;
        issue_instr(OP_DIV, SEW_64, 4'd3, acc);
        issue_instr(OP_MACC, SEW_8, 4'd4, acc);
        issue_instr(OP_DIV, SEW_64, 4'd5, acc);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        repeat (40) @(negedge clk_i);
        if (valid_seen != 0) begin
            abort_run("flush: a flushed instruction still reached writeback");
        end
        issue_instr(OP_ALU, SEW_32, 4'd6, acc);
        wait_returns(1);
        cmp_tag("flush", 4'd6, ret_tag[0]);
        cmp_lat("flush", rule_latency(OP_ALU, SEW_32), lat_t'(ret_edge[0] - acc - 1));
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        abort_run("timeout: no completion arrived");
    end

    initial begin
        seed       = 97;
        valid_seen = 0;
        rstn_i     = 1'b0;
        flush_i    = 1'b0;
        in_valid_i = 1'b0;
        in_op_i    = OP_ALU;
        in_sew_i   = SEW_8;
        in_tag_i   = '0;
        wb_ready_i = 1'b1;
        repeat (3) @(negedge clk_i);
        rstn_i = 1'b1;
        @(negedge clk_i);
        check_latencies();
        check_wb_conflict();
        check_div_serial();
        check_backpressure();
        check_flush();
        $display("Test passed");
        $finish;
    end

endmodule

/* verilog.f */
design/simd_issue_pkg.sv
design/issue_if.sv
design/complete_if.sv
design/simd_issue_buffer.sv
design/simd_scoreboard.sv
design/simd_wb_queue.sv
design/simd_issue_top.sv
dv/tb_simd_issue.sv
